//--- nf_cpu_pkg.sv
//--------------------------------------------------------------------------
// shared definitions of the nf_cpu core
//   isa and instruction field widths
//   funct3 and funct7 codes of the supported instructions
//   enums for major opcodes, alu operations and immediate formats
//--------------------------------------------------------------------------
`default_nettype none

package nf_cpu_pkg;

    // widths fixed by rv32i
    localparam int xlen       = 32;              // data and address width
    localparam int reg_addr_w = 5;               // register index
    localparam int reg_num    = 2 ** reg_addr_w; // x0 .. x31
    localparam int shamt_w    = 5;               // shift amount field
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int imm_w      = 12;              // i and b immediate bits
    localparam int pc_step    = 4;               // bytes per instruction

    // funct3 for r-type
    localparam logic [funct3_w-1:0] funct3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] funct3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] funct3_srl     = 3'b101;
    localparam logic [funct3_w-1:0] funct3_or      = 3'b110;
    localparam logic [funct3_w-1:0] funct3_and     = 3'b111;

    // funct3 for i-type
    localparam logic [funct3_w-1:0] funct3_addi    = 3'b000;
    localparam logic [funct3_w-1:0] funct3_ori     = 3'b110;

    // funct3 for b-type
    localparam logic [funct3_w-1:0] funct3_beq     = 3'b000;
    localparam logic [funct3_w-1:0] funct3_bne     = 3'b001;

    // funct7 variants
    localparam logic [funct7_w-1:0] funct7_zero    = 7'b0000000; // base encoding
    localparam logic [funct7_w-1:0] funct7_sub     = 7'b0100000; // sub

    // major opcodes handled by the core
    typedef enum logic [opcode_w-1:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011
    } opcode_t;

    // alu operation select
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_sll = 3'd2,
        alu_srl = 3'd3,
        alu_or  = 3'd4,
        alu_and = 3'd5,
        alu_lui = 3'd6   // src_b straight through
    } alu_op_t;

    // immediate format select
    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_u = 2'd1,
        imm_b = 2'd2
    } imm_src_t;

endpackage : nf_cpu_pkg

`default_nettype wire

//--- nf_cpu_if.sv
//--------------------------------------------------------------------------
// nf_ctrl_if  control bundle from decoder to datapath
// nf_rf_if    register file read and write ports
//--------------------------------------------------------------------------
`default_nettype none

interface nf_ctrl_if;

    import nf_cpu_pkg::*;

    alu_op_t    alu_op;     // alu operation
    imm_src_t   imm_src;    // immediate format
    logic       src_b_sel;  // 1 rd2, 0 immediate
    logic       we;         // register write
    logic       branch;     // branch instruction
    logic       eq_neq;     // 1 beq, 0 bne

    // driven by the control unit
    modport ctrl (output alu_op, imm_src, src_b_sel, we, branch, eq_neq);
    // read by datapath units
    modport dp   (input  alu_op, imm_src, src_b_sel, we, branch, eq_neq);

endinterface : nf_ctrl_if

interface nf_rf_if;

    import nf_cpu_pkg::*;

    logic [reg_addr_w-1:0] ra1;   // read address 1
    logic [xlen-1:0]       rd1;   // read data 1
    logic [reg_addr_w-1:0] ra2;   // read address 2
    logic [xlen-1:0]       rd2;   // read data 2
    logic [reg_addr_w-1:0] wa3;   // write address
    logic [xlen-1:0]       wd3;   // write data
    logic                  we3;   // write enable

    modport cpu (output ra1, ra2, wa3, wd3, we3, input  rd1, rd2);
    modport rf  (input  ra1, ra2, wa3, wd3, we3, output rd1, rd2);

endinterface : nf_rf_if

`default_nettype wire

//--- nf_control_unit.sv
//--------------------------------------------------------------------------
// nf_control_unit
//   combinational decoder of opcode, funct3 and funct7
//   drives the control bundle for the datapath
//--------------------------------------------------------------------------
`default_nettype none

module nf_control_unit (
    input  logic [nf_cpu_pkg::opcode_w-1:0] opcode,  // instr[6:0]
    input  logic [nf_cpu_pkg::funct3_w-1:0] funct3,  // instr[14:12]
    input  logic [nf_cpu_pkg::funct7_w-1:0] funct7,  // instr[31:25]
    nf_ctrl_if.ctrl                          ctrl
);

    import nf_cpu_pkg::*;

    opcode_t op;

    assign op = opcode_t'(opcode);

    always_comb begin
        // no-op unless decoded below
        ctrl.alu_op    = alu_add;
        ctrl.imm_src   = imm_i;
        ctrl.src_b_sel = 1'b0;
        ctrl.we        = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.eq_neq    = 1'b0;

        case (op)
            op_r: begin
                ctrl.src_b_sel = 1'b1;                    // register operand
                ctrl.we        = (funct7 == funct7_zero); // base encodings only
                case (funct3)
                    funct3_add_sub: begin
                        if (funct7 == funct7_sub) begin
                            ctrl.alu_op = alu_sub;
                            ctrl.we     = 1'b1;
                        end
                    end
                    funct3_sll: ctrl.alu_op = alu_sll;
                    funct3_srl: ctrl.alu_op = alu_srl;   // sra not supported
                    funct3_or:  ctrl.alu_op = alu_or;
                    funct3_and: ctrl.alu_op = alu_and;
                    default:    ctrl.we     = 1'b0;      // slt, sltu, xor
                endcase
            end
            op_imm: begin
                ctrl.imm_src = imm_i;
                case (funct3)
                    funct3_addi: begin
                        ctrl.alu_op = alu_add;
                        ctrl.we     = 1'b1;
                    end
                    funct3_ori: begin
                        ctrl.alu_op = alu_or;
                        ctrl.we     = 1'b1;
                    end
                    default: ctrl.we = 1'b0;
                endcase
            end
            op_lui: begin
                ctrl.alu_op  = alu_lui;   // u immediate passes through
                ctrl.imm_src = imm_u;
                ctrl.we      = 1'b1;
            end
            op_branch: begin
                ctrl.imm_src   = imm_b;
                ctrl.src_b_sel = 1'b1;
                // compare done at top level, no write back
                case (funct3)
                    funct3_beq: begin
                        ctrl.branch = 1'b1;
                        ctrl.eq_neq = 1'b1;
                    end
                    funct3_bne: ctrl.branch = 1'b1;
                    default:    ctrl.branch = 1'b0;  // blt and friends
                endcase
            end
            default: ;   // unknown opcode keeps the no-op
        endcase
    end

endmodule : nf_control_unit

`default_nettype wire

//--- nf_reg_file.sv
//--------------------------------------------------------------------------
// nf_reg_file
//   31 writable registers with x0 reading zero
//   two operand read ports, one debug read port, one clocked write
//--------------------------------------------------------------------------
`default_nettype none

module nf_reg_file (
    input  logic                              clk,
    input  logic                              arst_n,
    nf_rf_if.rf                               rf,
    input  logic [nf_cpu_pkg::reg_addr_w-1:0] ra0,    // debug address
    output logic [nf_cpu_pkg::xlen-1:0]       rd0     // debug data
);

    import nf_cpu_pkg::*;

    logic [xlen-1:0] regs [1:reg_num-1];   // no storage for x0

    // asynchronous reads with x0 forced to zero
    assign rf.rd1 = (rf.ra1 == '0) ? '0 : regs[rf.ra1];
    assign rf.rd2 = (rf.ra2 == '0) ? '0 : regs[rf.ra2];
    assign rd0    = (ra0    == '0) ? '0 : regs[ra0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < reg_num; i++) begin
                regs[reg_addr_w'(i)] <= '0;
            end
        end else if (rf.we3 && (rf.wa3 != '0)) begin
            regs[rf.wa3] <= rf.wd3;   // writes to x0 dropped
        end
    end

endmodule : nf_reg_file

`default_nettype wire

//--- nf_alu.sv
//--------------------------------------------------------------------------
// nf_alu
//   add, sub, logical shifts, or, and
//   pass of src_b for lui
//--------------------------------------------------------------------------
`default_nettype none

module nf_alu (
    input  logic [nf_cpu_pkg::xlen-1:0]    src_a,    // rd1
    input  logic [nf_cpu_pkg::xlen-1:0]    src_b,    // rd2 or immediate
    input  logic [nf_cpu_pkg::shamt_w-1:0] shamt,    // instr[24:20]
    nf_ctrl_if.dp                           ctrl,
    output logic [nf_cpu_pkg::xlen-1:0]    result
);

    import nf_cpu_pkg::*;

    logic [shamt_w-1:0] sh_amt;

    // register form takes low bits of rd2, immediate form the shamt field
    assign sh_amt = ctrl.src_b_sel ? src_b[shamt_w-1:0] : shamt;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: result = src_a + src_b;
            alu_sub: result = src_a - src_b;
            alu_sll: result = src_a << sh_amt;
            alu_srl: result = src_a >> sh_amt;   // logical
            alu_or:  result = src_a | src_b;
            alu_and: result = src_a & src_b;
            alu_lui: result = src_b;             // u immediate already placed
            default: result = '0;
        endcase
    end

endmodule : nf_alu

`default_nettype wire

//--- nf_sign_ex.sv
//--------------------------------------------------------------------------
// nf_sign_ex
//   immediate gathering for i, u and b formats
//   sign extension to xlen
//--------------------------------------------------------------------------
`default_nettype none

module nf_sign_ex (
    input  logic [nf_cpu_pkg::xlen-1:0] instr,
    nf_ctrl_if.dp                        ctrl,
    output logic [nf_cpu_pkg::xlen-1:0] imm_ex
);

    import nf_cpu_pkg::*;

    logic [imm_w-1:0] imm_i_bits;
    logic [imm_w-1:0] imm_b_bits;   // offset in halfwords

    assign imm_i_bits = instr[31:20];
    assign imm_b_bits = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        case (ctrl.imm_src)
            imm_i:   imm_ex = {{(xlen-imm_w){imm_i_bits[imm_w-1]}}, imm_i_bits};
            imm_u:   imm_ex = {instr[xlen-1:imm_w], {imm_w{1'b0}}};  // upper 20 bits
            imm_b:   imm_ex = {{(xlen-imm_w){imm_b_bits[imm_w-1]}}, imm_b_bits};
            default: imm_ex = '0;
        endcase
    end

endmodule : nf_sign_ex

`default_nettype wire

//--- nf_cpu.sv
//--------------------------------------------------------------------------
// nf_cpu  single-cycle rv32i subset core
//   program counter and next-pc selection
//   instruction field extraction, branch compare, source b mux
//   control unit, register file, alu and sign extender instances
//--------------------------------------------------------------------------
`default_nettype none

module nf_cpu (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              cpu_en,      // freezes pc and writes
    output logic [nf_cpu_pkg::xlen-1:0]       instr_addr,  // registered pc
    input  logic [nf_cpu_pkg::xlen-1:0]       instr,       // same-cycle fetch data
    input  logic [nf_cpu_pkg::reg_addr_w-1:0] reg_addr,    // debug read
    output logic [nf_cpu_pkg::xlen-1:0]       reg_data
);

    import nf_cpu_pkg::*;

    // decoded instruction fields
    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;
    logic [shamt_w-1:0]  shamt;
    // datapath
    logic [xlen-1:0]     imm_ex;
    logic [xlen-1:0]     src_b;
    logic [xlen-1:0]     result;
    // next pc
    logic [xlen-1:0]     pc_nb;        // sequential
    logic [xlen-1:0]     pc_b;         // branch target
    logic [xlen-1:0]     pc_next;
    logic                rd_eq;
    logic                branch_taken;

    nf_ctrl_if ctrl_if ();
    nf_rf_if   rf_if ();

    // field extraction
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign shamt  = instr[24:20];

    // register file hookup
    assign rf_if.ra1 = instr[19:15];          // rs1
    assign rf_if.ra2 = instr[24:20];          // rs2
    assign rf_if.wa3 = instr[11:7];           // rd
    assign rf_if.wd3 = result;
    assign rf_if.we3 = ctrl_if.we & cpu_en;   // no write while frozen

    assign src_b = ctrl_if.src_b_sel ? rf_if.rd2 : imm_ex;

    // beq on equal, bne on not equal
    assign rd_eq        = (rf_if.rd1 == rf_if.rd2);
    assign branch_taken = ctrl_if.branch & (rd_eq == ctrl_if.eq_neq);

    assign pc_nb   = instr_addr + xlen'(pc_step);
    assign pc_b    = instr_addr + (imm_ex << 1);   // b offset in halfwords
    assign pc_next = branch_taken ? pc_b : pc_nb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_addr <= '0;
        end else if (cpu_en) begin
            instr_addr <= pc_next;
        end
    end

    nf_control_unit nf_control_unit_0 (
        .opcode  ( opcode   ),
        .funct3  ( funct3   ),
        .funct7  ( funct7   ),
        .ctrl    ( ctrl_if  )
    );

    nf_reg_file reg_file_0 (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .rf      ( rf_if    ),
        .ra0     ( reg_addr ),   // debug port
        .rd0     ( reg_data )
    );

    nf_alu alu_0 (
        .src_a   ( rf_if.rd1 ),
        .src_b   ( src_b     ),
        .shamt   ( shamt     ),
        .ctrl    ( ctrl_if   ),
        .result  ( result    )
    );

    nf_sign_ex sign_ex_0 (
        .instr   ( instr    ),
        .ctrl    ( ctrl_if  ),
        .imm_ex  ( imm_ex   )
    );

endmodule : nf_cpu

`default_nettype wire

//--- tb_nf_cpu.sv
//----------------------------------------------------------------------------
// testbench of the nf_cpu core
//   instruction memory filled with random legal instructions from an lfsr
//   reference model of the rv32i subset with its own pc and registers
//   reset scan, per-cycle pc and debug port checks, final scan, timeout
//----------------------------------------------------------------------------
`default_nettype none

module tb_nf_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    import nf_cpu_pkg::*;

    localparam int clk_period     = 4;
    localparam int reset_cycles   = 3;
    localparam int run_cycles     = 2000;
    localparam int scan_cycles    = 2 * reg_num;   // reset scan plus final scan
    localparam int margin_cycles  = 100;
    localparam int timeout_cycles = reset_cycles + run_cycles + scan_cycles + margin_cycles;
    localparam int imem_words     = 64;
    localparam logic [31:0] lfsr_seed = 32'h660774b9;
    localparam logic [31:0] lfsr_taps = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

    // dut ports
    logic                  clk;
    logic                  arst_n;
    logic                  cpu_en;
    logic [xlen-1:0]       instr_addr;
    logic [xlen-1:0]       instr;
    logic [reg_addr_w-1:0] reg_addr;
    logic [xlen-1:0]       reg_data;

    logic [xlen-1:0] imem [0:imem_words-1];   // word addressed, wraps
    logic [xlen-1:0] m_regs [0:reg_num-1];    // model register file
    logic [xlen-1:0] m_pc;                    // model pc
    logic [31:0]     lfsr;
    logic            en_drv;                  // cpu_en seen by the next edge
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;

    assign instr = imem[instr_addr[7:2]];   // same-cycle fetch

    nf_cpu nf_cpu_i (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_en     ( cpu_en     ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .reg_addr   ( reg_addr   ),
        .reg_data   ( reg_data   )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one galois step, shift right with feedback from bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};   // one step per bit
        end
        return val;
    endfunction

    task automatic compare_word(input string name, input logic [xlen-1:0] expected,
                                input logic [xlen-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic fill_imem();
        logic [3:0]  kind;
        logic [2:0]  sel;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd, rs1, rs2;
        logic [4:0]  words;   // signed branch distance
        logic [12:0] off;     // byte offset
        for (int i = 0; i < imem_words; i++) begin
            kind = 4'(rand_bits(4));
            rd   = 5'(rand_bits(5));
            rs1  = 5'(rand_bits(5));
            rs2  = 5'(rand_bits(5));
            sel  = 3'(rand_bits(3));
            if (kind < 4'd6) begin   // r-type
                f7 = (sel == 3'd1 || sel == 3'd7) ? funct7_sub : funct7_zero;
                case (sel)
                    3'd2:    f3 = funct3_sll;
                    3'd3:    f3 = funct3_srl;
                    3'd4:    f3 = funct3_or;
                    3'd5:    f3 = funct3_and;
                    default: f3 = funct3_add_sub;   // add or sub
                endcase
                imem[6'(i)] = {f7, rs2, rs1, f3, rd, op_r};
            end else if (kind < 4'd10) begin
                f3 = sel[0] ? funct3_ori : funct3_addi;
                imem[6'(i)] = {12'(rand_bits(12)), rs1, f3, rd, op_imm};
            end else if (kind < 4'd12) begin
                imem[6'(i)] = {20'(rand_bits(20)), rd, op_lui};
            end else begin
                // beq or bne within +-16 words
                words = 5'(rand_bits(5));
                if (words == 5'd0) begin
                    words = 5'd1;   // avoid self loop
                end
                off = {{6{words[4]}}, words, 2'b00};
                if (rand_bits(2) == 32'd0) begin
                    rs2 = rs1;   // equal operands now and then
                end
                f3 = sel[0] ? funct3_bne : funct3_beq;
                imem[6'(i)] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
            end
        end
    endtask

    task automatic model_reset();
        m_pc = '0;
        for (int r = 0; r < reg_num; r++) begin
            m_regs[5'(r)] = '0;
        end
    endtask

    // executes the instruction at the model pc
    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a, b;
        logic [31:0] imm_i, imm_u, off_b;
        logic [31:0] res;
        logic [31:0] pc_next;
        logic [4:0]  rd;
        logic        wr;
        ins     = imem[m_pc[7:2]];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        rd      = ins[11:7];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_u   = {ins[31:12], 12'h000};
        off_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res     = '0;
        wr      = 1'b0;
        pc_next = m_pc + 32'd4;
        case (opcode_t'(ins[6:0]))
            op_r: begin
                wr = 1'b1;
                case (ins[14:12])
                    funct3_add_sub: res = (ins[31:25] == funct7_sub) ? a - b : a + b;
                    funct3_sll:     res = a << b[4:0];
                    funct3_srl:     res = a >> b[4:0];
                    funct3_or:      res = a | b;
                    funct3_and:     res = a & b;
                    default:        wr  = 1'b0;
                endcase
            end
            op_imm: begin
                wr  = 1'b1;
                res = (ins[14:12] == funct3_ori) ? (a | imm_i) : (a + imm_i);
            end
            op_lui: begin
                wr  = 1'b1;
                res = imm_u;
            end
            op_branch: begin
                if ((ins[14:12] == funct3_beq && a == b) ||
                    (ins[14:12] == funct3_bne && a != b)) begin
                    pc_next = m_pc + off_b;   // taken
                end
            end
            default: ;
        endcase
        if (wr && rd != 5'd0) begin
            m_regs[rd] = res;   // x0 stays zero
        end
        m_pc = pc_next;
    endtask

    // reads every register through the debug port with the core frozen
    task automatic scan_regs();
        for (int r = 0; r < reg_num; r++) begin
            @(posedge clk);
            if (en_drv) begin
                model_step();
            end
            en_drv = 1'b0;
            cpu_en   <= 1'b0;
            reg_addr <= 5'(r);
            @(negedge clk);
            compare_word($sformatf("reg_data x%0d", r), m_regs[5'(r)], reg_data);
        end
        compare_word("instr_addr", m_pc, instr_addr);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("timeout after %0d cycles, the run did not reach its end", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        arst_n   = 1'b0;
        cpu_en   = 1'b0;
        reg_addr = '0;
        en_drv   = 1'b0;
        lfsr     = lfsr_seed;
        fill_imem();
        model_reset();

        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_word("instr_addr after reset", 32'h0, instr_addr);
        scan_regs();   // all zero after reset

        for (int n = 0; n < run_cycles; n++) begin
            @(posedge clk);
            if (en_drv) begin
                model_step();   // edge just taken ran one instruction
            end
            en_drv = (3'(rand_bits(3)) != 3'd0);   // about 1 in 8 frozen
            cpu_en   <= en_drv;
            reg_addr <= 5'(rand_bits(5));
            @(negedge clk);
            compare_word("instr_addr", m_pc, instr_addr);
            compare_word($sformatf("reg_data x%0d", reg_addr), m_regs[reg_addr], reg_data);
        end

        scan_regs();   // final state

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_nf_cpu

`default_nettype wire

//--- tb.f
nf_cpu_pkg.sv
nf_cpu_if.sv
nf_control_unit.sv
nf_reg_file.sv
nf_alu.sv
nf_sign_ex.sv
nf_cpu.sv
tb_nf_cpu.sv

//--- Makefile
# Verilator build and run of the nf_cpu testbench

VERILATOR ?= verilator
TOP       ?= tb_nf_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
